/* list.f */
+incdir+verif
logic/corePkg.sv
logic/FetchUnit.sv
logic/InstrDecoder.sv
logic/RegFile.sv
logic/ExecLanes.sv
logic/CommitStage.sv
logic/Core.sv
verif/CoreTb.sv

/* logic/CommitStage.sv */
`timescale 1ns/1ps

module CommitStage (
    input  logic clk,
    input  logic rst,
    input  corePkg::commitSlot [corePkg::LANES-1:0] results,
    output corePkg::commitSlot [corePkg::LANES-1:0] commits,
    output logic [corePkg::LANES-1:0] writeEnable,
    output corePkg::regName [corePkg::LANES-1:0] writeAddr,
    output corePkg::regData [corePkg::LANES-1:0] writeData
);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int l = 0; l < corePkg::LANES; l++) begin
                commits[l].valid <= 1'b0;
            end
        end else begin
            commits <= results;
        end
    end

    // A lane has a result only if it is valid and targets a real register.
    always_comb begin
        for (int l = 0; l < corePkg::LANES; l++) begin
            writeEnable[l] = commits[l].valid && commits[l].rd != '0;
            writeAddr[l] = commits[l].rd;
            writeData[l] = commits[l].value;
        end
    end

endmodule

/* logic/Core.sv */
`timescale 1ns/1ps

module Core #(
    parameter int AddrWidth = 10
) (
    input  logic clk,
    input  logic rst,
    input  logic en,
    input  corePkg::instrBundle instrRaw,
    output logic [AddrWidth-1:0] instrAddr,
    output logic fetchEn,
    output corePkg::commitSlot [corePkg::LANES-1:0] commits
);

    corePkg::instrBundle bundle;
    logic bundleValid;
    logic advance;

    corePkg::decodedOp [corePkg::LANES-1:0] ops;

    corePkg::regName [2*corePkg::LANES-1:0] readAddr;
    corePkg::regData [2*corePkg::LANES-1:0] readData;

    corePkg::commitSlot [corePkg::LANES-1:0] results;

    logic [corePkg::LANES-1:0] writeEnable;
    corePkg::regName [corePkg::LANES-1:0] writeAddr;
    corePkg::regData [corePkg::LANES-1:0] writeData;

    FetchUnit #(
        .AddrWidth(AddrWidth)
    ) fetch (
        .clk(clk),
        .rst(rst),
        .en(en),
        .instrRaw(instrRaw),
        .instrAddr(instrAddr),
        .fetchEn(fetchEn),
        .bundle(bundle),
        .bundleValid(bundleValid),
        .advance(advance)
    );

    InstrDecoder decode (
        .clk(clk),
        .rst(rst),
        .advance(advance),
        .bundle(bundle),
        .bundleValid(bundleValid),
        .ops(ops)
    );

    ExecLanes exec (
        .advance(advance),
        .ops(ops),
        .readData(readData),
        .commitFwd(commits),    // Writeback stage forwards until the register file catches up.
        .readAddr(readAddr),
        .results(results)
    );

    RegFile regFile (
        .clk(clk),
        .rst(rst),
        .readAddr(readAddr),
        .writeEnable(writeEnable),
        .writeAddr(writeAddr),
        .writeData(writeData),
        .readData(readData)
    );

    CommitStage commit (
        .clk(clk),
        .rst(rst),
        .results(results),
        .commits(commits),
        .writeEnable(writeEnable),
        .writeAddr(writeAddr),
        .writeData(writeData)
    );

endmodule

/* logic/ExecLanes.sv */
`timescale 1ns/1ps

module ExecLanes (
    input  logic advance,
    input  corePkg::decodedOp [corePkg::LANES-1:0] ops,
    input  corePkg::regData [2*corePkg::LANES-1:0] readData,
    input  corePkg::commitSlot [corePkg::LANES-1:0] commitFwd,
    output corePkg::regName [2*corePkg::LANES-1:0] readAddr,
    output corePkg::commitSlot [corePkg::LANES-1:0] results
);

    // The newest producer of a register wins.
    function automatic corePkg::regData selectOperand(
        input corePkg::regName src,
        input corePkg::regData rfData,
        input corePkg::commitSlot chain,
        input corePkg::commitSlot [corePkg::LANES-1:0] fwd
    );
        corePkg::regData value;
        value = rfData;
        for (int l = 0; l < corePkg::LANES; l++) begin
            if (fwd[l].valid && fwd[l].rd == src) begin
                value = fwd[l].value;
            end
        end
        if (chain.valid && chain.rd == src) begin
            value = chain.value;   // Result from an older lane of this same bundle.
        end
        return value;
    endfunction

    function automatic corePkg::regData aluCompute(
        input corePkg::aluOp op,
        input corePkg::regData a,
        input corePkg::regData b
    );
        case (op)
            corePkg::AluAdd: return a + b;
            corePkg::AluSub: return a - b;
            corePkg::AluAnd: return a & b;
            corePkg::AluOr:  return a | b;
            corePkg::AluXor: return a ^ b;
            default:         return '0;
        endcase
    endfunction

    always_comb begin
        for (int l = 0; l < corePkg::LANES; l++) begin
            readAddr[2*l] = ops[l].rs1;
            readAddr[2*l+1] = ops[l].rs2;
        end
    end

    always_comb begin
        corePkg::commitSlot chain;
        corePkg::regData srcA;
        corePkg::regData srcB;
        chain = '0;
        for (int l = 0; l < corePkg::LANES; l++) begin
            srcA = selectOperand(ops[l].rs1, readData[2*l], chain, commitFwd);
            if (ops[l].useImm) begin
                srcB = ops[l].imm;
            end else begin
                srcB = selectOperand(ops[l].rs2, readData[2*l+1], chain, commitFwd);
            end
            results[l].valid = advance && ops[l].valid;   // Bubbles while stalled.
            results[l].rd = ops[l].rd;
            if (ops[l].rd == '0) begin
                results[l].value = '0;
            end else begin
                results[l].value = aluCompute(ops[l].op, srcA, srcB);
            end
            chain = results[l];
        end
    end

endmodule

/* logic/FetchUnit.sv */
`timescale 1ns/1ps

module FetchUnit #(
    parameter int AddrWidth = 10
) (
    input  logic clk,
    input  logic rst,
    input  logic en,
    input  corePkg::instrBundle instrRaw,
    output logic [AddrWidth-1:0] instrAddr,
    output logic fetchEn,
    output corePkg::instrBundle bundle,
    output logic bundleValid,
    output logic advance
);

    // Bit 0 is the address stage, bit 1 the ROM data stage, bit 2 the bundle register.
    logic [2:0] stageValid;

    corePkg::instrBundle rawBackup;
    logic useBackup;
    corePkg::instrBundle rawBundle;

    assign advance = en && stageValid[0];
    assign fetchEn = advance;       // Every advancing cycle requests the next bundle.
    assign bundleValid = stageValid[2];

    // The ROM only drives the word for one cycle, so a stall must keep its own copy.
    assign rawBundle = useBackup ? rawBackup : instrRaw;

    always_ff @(posedge clk) begin
        if (rst) begin
            stageValid <= 3'b000;
        end else if (en) begin
            stageValid <= {stageValid[1:0], 1'b1};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            instrAddr <= '0;
        end else if (advance) begin
            instrAddr <= instrAddr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            useBackup <= 1'b0;
        end else if (!advance) begin
            rawBackup <= rawBundle;     // Recirculates once the backup is in use.
            useBackup <= 1'b1;
        end else begin
            useBackup <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            bundle <= rawBundle;
        end
    end

endmodule

/* logic/InstrDecoder.sv */
`timescale 1ns/1ps

module InstrDecoder (
    input  logic clk,
    input  logic rst,
    input  logic advance,
    input  corePkg::instrBundle bundle,
    input  logic bundleValid,
    output corePkg::decodedOp [corePkg::LANES-1:0] ops
);

    localparam logic [6:0] OpcodeReg = 7'b0110011;
    localparam logic [6:0] OpcodeImm = 7'b0010011;

    corePkg::decodedOp [corePkg::LANES-1:0] decoded;

    function automatic corePkg::decodedOp decodeWord(input corePkg::instrWord word);
        corePkg::decodedOp dec;
        dec = '0;
        dec.op = corePkg::AluNone;
        if (word[6:0] == OpcodeReg) begin
            case ({word[31:25], word[14:12]})
                {7'b0000000, 3'b000}: dec.op = corePkg::AluAdd;
                {7'b0100000, 3'b000}: dec.op = corePkg::AluSub;
                {7'b0000000, 3'b111}: dec.op = corePkg::AluAnd;
                {7'b0000000, 3'b110}: dec.op = corePkg::AluOr;
                {7'b0000000, 3'b100}: dec.op = corePkg::AluXor;
                default: dec.op = corePkg::AluNone;
            endcase
            if (dec.op != corePkg::AluNone) begin
                dec.rd = word[11:7];
                dec.rs1 = word[19:15];
                dec.rs2 = word[24:20];
            end
        end else if (word[6:0] == OpcodeImm && word[14:12] == 3'b000) begin
            dec.op = corePkg::AluAdd;   // ADDI reuses the adder.
            dec.rd = word[11:7];
            dec.rs1 = word[19:15];
            dec.useImm = 1'b1;
            dec.imm = {{20{word[31]}}, word[31:20]};
        end
        return dec;
    endfunction

    always_comb begin
        for (int l = 0; l < corePkg::LANES; l++) begin
            decoded[l] = decodeWord(bundle[32*l +: 32]);
            decoded[l].valid = bundleValid;
        end
    end

    // The register holds its bundle until the back end takes it on an advancing cycle.
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int l = 0; l < corePkg::LANES; l++) begin
                ops[l].valid <= 1'b0;
            end
        end else if (advance) begin
            ops <= decoded;
        end
    end

endmodule

/* logic/RegFile.sv */
`timescale 1ns/1ps

module RegFile (
    input  logic clk,
    input  logic rst,
    input  corePkg::regName [2*corePkg::LANES-1:0] readAddr,
    input  logic [corePkg::LANES-1:0] writeEnable,
    input  corePkg::regName [corePkg::LANES-1:0] writeAddr,
    input  corePkg::regData [corePkg::LANES-1:0] writeData,
    output corePkg::regData [2*corePkg::LANES-1:0] readData
);

    corePkg::regData regs [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < 32; r++) begin
                regs[r] <= '0;
            end
        end else begin
            // Later ports are written last, so lane 1 wins on a clash.
            for (int w = 0; w < corePkg::LANES; w++) begin
                if (writeEnable[w]) begin
                    regs[writeAddr[w]] <= writeData[w];
                end
            end
        end
    end

    always_comb begin
        for (int p = 0; p < 2*corePkg::LANES; p++) begin
            readData[p] = (readAddr[p] == '0) ? '0 : regs[readAddr[p]];
        end
    end

endmodule

/* logic/corePkg.sv */
package corePkg;

    // Instructions per fetch bundle.
    parameter int LANES = 2;

    typedef logic [31:0] instrWord;

    // Lane 0 sits in the low half, lane 1 in the high half.
    typedef logic [32*LANES-1:0] instrBundle;

    typedef logic [4:0] regName;
    typedef logic [31:0] regData;

    typedef enum logic [2:0] {
        AluAdd,
        AluSub,
        AluAnd,
        AluOr,
        AluXor,
        AluNone
    } aluOp;

    // One decoded instruction as it leaves the decode stage.
    typedef struct packed {
        logic valid;
        aluOp op;
        regName rd;
        regName rs1;
        regName rs2;
        logic useImm;   // Operand B comes from imm instead of rs2.
        regData imm;    // Sign-extended from the 12-bit I-type field.
    } decodedOp;

    // One lane's result on its way to the register file.
    typedef struct packed {
        logic valid;
        regName rd;
        regData value;
    } commitSlot;

endpackage

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f list.f --top-module CoreTb -o CoreTbSim
./obj_dir/CoreTbSim > sim.log 2>&1
cat sim.log

if grep -q "All checks passed" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

/* verif/coreModel.svh */
`ifndef CORE_MODEL_SVH
`define CORE_MODEL_SVH

localparam int KindAdd = 0;
localparam int KindSub = 1;
localparam int KindAnd = 2;
localparam int KindOr = 3;
localparam int KindXor = 4;
localparam int KindAddi = 5;

localparam logic [6:0] RegOpcode = 7'b0110011;
localparam logic [6:0] ImmOpcode = 7'b0010011;

// One expected commit, tagged with the kind of dependency it exercises.
typedef struct packed {
    corePkg::regName rd;
    corePkg::regData value;
    logic chained;      // Lane 1 reads the rd of lane 0 in the same bundle.
    logic forwarded;    // Reads a register written one or two bundles earlier.
} expectEntry;

corePkg::regData modelRegs [32];

task automatic resetModel();
    for (int r = 0; r < 32; r++) begin
        modelRegs[r] = '0;
    end
endtask

function automatic corePkg::instrWord encodeOp(input int kind, input corePkg::regName rd,
        input corePkg::regName rs1, input corePkg::regName rs2, input logic [11:0] imm);
    case (kind)
        KindAdd: return {7'b0000000, rs2, rs1, 3'b000, rd, RegOpcode};
        KindSub: return {7'b0100000, rs2, rs1, 3'b000, rd, RegOpcode};
        KindAnd: return {7'b0000000, rs2, rs1, 3'b111, rd, RegOpcode};
        KindOr:  return {7'b0000000, rs2, rs1, 3'b110, rd, RegOpcode};
        KindXor: return {7'b0000000, rs2, rs1, 3'b100, rd, RegOpcode};
        default: return {imm, rs1, 3'b000, rd, ImmOpcode};
    endcase
endfunction

// Executes one instruction on the architectural state and returns its result.
function automatic corePkg::regData executeOp(input int kind, input corePkg::regName rd,
        input corePkg::regName rs1, input corePkg::regName rs2, input logic [11:0] imm);
    corePkg::regData a;
    corePkg::regData b;
    corePkg::regData result;
    a = modelRegs[rs1];
    b = (kind == KindAddi) ? {{20{imm[11]}}, imm} : modelRegs[rs2];
    case (kind)
        KindSub: result = a - b;
        KindAnd: result = a & b;
        KindOr:  result = a | b;
        KindXor: result = a ^ b;
        default: result = a + b;
    endcase
    if (rd == '0) begin
        result = '0;    // Register 0 never holds a value.
    end else begin
        modelRegs[rd] = result;
    end
    return result;
endfunction

`endif

/* verif/CoreTb.sv */
`timescale 1ns/1ps

module CoreTb;

    `include "coreModel.svh"

    localparam int ProgramBundles = 64;
    localparam int ProgramInstrs = ProgramBundles * corePkg::LANES;
    localparam int RomDepth = 1024;
    localparam int TimeoutCycles = 8 * ProgramBundles + 100;
    localparam int TestCount = 5;
    localparam int TestOrder = 0;
    localparam int TestChain = 1;
    localparam int TestForward = 2;
    localparam int TestStall = 3;
    localparam int TestZero = 4;

    logic clk;
    logic rst;
    logic en;
    corePkg::instrBundle instrRaw;
    logic [9:0] instrAddr;
    logic fetchEn;
    corePkg::commitSlot [corePkg::LANES-1:0] commits;

    corePkg::instrBundle romData [RomDepth];
    expectEntry expectQ [$];
    int checkCount [TestCount];
    int failCount [TestCount];
    string testNames [TestCount];
    int programCommits;
    int cycleCount;
    logic prevRst;
    logic running;

    Core UUT (
        .clk(clk),
        .rst(rst),
        .en(en),
        .instrRaw(instrRaw),
        .instrAddr(instrAddr),
        .fetchEn(fetchEn),
        .commits(commits)
    );

    task automatic buildProgram();
        int lastWrite [32];
        int kind;
        corePkg::regName rd;
        corePkg::regName rs1;
        corePkg::regName rs2;
        corePkg::regName firstRd;
        logic [11:0] imm;
        corePkg::instrBundle bundleWord;
        expectEntry entry;
        for (int r = 0; r < 32; r++) begin
            lastWrite[r] = -10;
        end
        for (int b = 0; b < ProgramBundles; b++) begin
            firstRd = '0;
            for (int l = 0; l < corePkg::LANES; l++) begin
                kind = $urandom % 6;
                rd = 5'($urandom % 8);     // Few registers keep dependencies frequent.
                rs1 = 5'($urandom % 8);
                rs2 = 5'($urandom % 8);
                imm = 12'($urandom);
                if (l == 1 && $urandom % 3 == 0) begin
                    rs1 = firstRd;
                end
                bundleWord[32*l +: 32] = encodeOp(kind, rd, rs1, rs2, imm);
                entry.rd = rd;
                entry.chained = (l == 1) && (firstRd != '0)
                    && (rs1 == firstRd || (kind != KindAddi && rs2 == firstRd));
                entry.forwarded = (b - lastWrite[rs1] <= 2)
                    || (kind != KindAddi && b - lastWrite[rs2] <= 2);
                entry.value = executeOp(kind, rd, rs1, rs2, imm);
                expectQ.push_back(entry);
                if (l == 0) begin
                    firstRd = rd;
                end
            end
            if (firstRd != '0) begin
                lastWrite[firstRd] = b;
            end
            if (rd != '0) begin
                lastWrite[rd] = b;
            end
            romData[b] = bundleWord;
        end
        // Past the program every lane is an ADDI to x0 stamped with its address.
        for (int a = ProgramBundles; a < RomDepth; a++) begin
            romData[a] = {encodeOp(KindAddi, 5'd0, 5'd0, 5'd0, ~12'(a)),
                          encodeOp(KindAddi, 5'd0, 5'd0, 5'd0, 12'(a))};
        end
    endtask

    task automatic reportFailure(input int test, input string msg);
        failCount[test]++;
        $display("CHECK FAILED at %0t: %s", $time, msg);
    endtask

    task automatic checkCommit(input int lane, input corePkg::commitSlot got);
        expectEntry exp;
        int test;
        if (programCommits < ProgramInstrs) begin
            exp = expectQ.pop_front();
            test = (exp.rd == '0) ? TestZero : exp.chained ? TestChain
                : exp.forwarded ? TestForward : TestOrder;
            checkCount[test]++;
            if (got.rd != exp.rd || got.value != exp.value) begin
                reportFailure(test, $sformatf(
                    "instruction %0d lane %0d expected x%0d = %h, got x%0d = %h",
                    programCommits, lane, exp.rd, exp.value, got.rd, got.value));
            end
            programCommits++;
        end else begin
            checkCount[TestStall]++;
            if (got.rd != '0 || got.value != '0) begin
                reportFailure(TestStall, $sformatf("extra commit x%0d = %h after the program",
                    got.rd, got.value));
            end
        end
    endtask

    task automatic finishRun();
        int totalChecks;
        int totalFails;
        totalChecks = 0;
        totalFails = 0;
        for (int t = 0; t < TestCount; t++) begin
            $display("Test %0d (%s): %0d checks, %0d failed", t + 1, testNames[t],
                checkCount[t], failCount[t]);
            totalChecks += checkCount[t];
            totalFails += failCount[t];
        end
        $display("Total: %0d checks, %0d failed", totalChecks, totalFails);
        if (totalFails == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        void'($urandom(52));
        rst = 1'b1;
        en = 1'b0;
        instrRaw = '0;
        prevRst = 1'b0;
        running = 1'b0;
        programCommits = 0;
        cycleCount = 0;
        testNames = '{"commit order and values", "same-bundle dependency",
            "back-to-back dependency", "stall survival", "register 0 and reset"};
        for (int t = 0; t < TestCount; t++) begin
            checkCount[t] = 0;
            failCount[t] = 0;
        end
        resetModel();
        buildProgram();
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        running <= 1'b1;
        while (programCommits < ProgramInstrs && cycleCount < TimeoutCycles) begin
            @(posedge clk);
        end
        checkCount[TestStall]++;
        if (programCommits != ProgramInstrs) begin
            failCount[TestStall]++;
            $display("Timeout after %0d cycles with %0d of %0d program instructions committed",
                cycleCount, programCommits, ProgramInstrs);
        end
        repeat (10) @(posedge clk);     // Lets any duplicate commit show up.
        finishRun();
    end

    // En is high three cycles out of four.
    always @(posedge clk) begin
        if (running) begin
            en <= ($urandom % 4) != 0;
        end
    end

    // ROM with one cycle of valid data after each fetch, garbage otherwise.
    always @(posedge clk) begin
        if (fetchEn) begin
            instrRaw <= romData[instrAddr];
        end else begin
            instrRaw <= {$urandom, $urandom};
        end
    end

    always @(negedge clk) begin
        for (int l = 0; l < corePkg::LANES; l++) begin
            if (rst || prevRst) begin
                checkCount[TestZero]++;
                if (commits[l].valid !== 1'b0) begin
                    reportFailure(TestZero, $sformatf("lane %0d commit valid around reset", l));
                end
            end else if (commits[l].valid) begin
                checkCommit(l, commits[l]);
            end
        end
        checkCount[TestStall]++;
        if (fetchEn && !en) begin
            reportFailure(TestStall, "fetch requested while en is low");
        end
        prevRst = rst;
    end

    always @(posedge clk) begin
        cycleCount++;
    end

endmodule
